// File: logic/iq_geom_pkg.sv
package iq_geom_pkg;

  // ****************************************
  // queue geometry
  // ****************************************

  // number of entries in the ring
  localparam int DEPTH     = 16;

  // entries are grouped in banks for the read mux
  localparam int BANK_SIZE = 4;
  localparam int NUM_BANKS = DEPTH / BANK_SIZE;

  // most lanes either port of the queue may have
  localparam int MAX_LANES = 4;

  localparam int PTR_W = $clog2(DEPTH);
  // count has to reach DEPTH itself
  localparam int CNT_W = $clog2(DEPTH + 1);

  // ****************************************
  // index types
  // ****************************************

  typedef logic [PTR_W-1:0] iq_ptr_t;
  typedef logic [CNT_W-1:0] iq_count_t;

endpackage

// File: logic/iq_payload_pkg.sv
package iq_payload_pkg;

  // ****************************************
  // payload widths
  // ****************************************

  // raw instruction word from fetch
  localparam int INSTR_W = 32;

  // predecode bits that ride along with each word
  localparam int META_W  = 8;

  // ****************************************
  // payload types
  // ****************************************

  typedef logic [INSTR_W-1:0] iq_instr_t;

  typedef logic [META_W-1:0]  iq_meta_t;

endpackage

// File: logic/iq_lane_addr.sv
`timescale 1ns/100ps

module iq_lane_addr #(
  parameter int LANES = 4
) (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             flush,
  input  logic                             advance,
  input  logic                 [LANES-1:0] lane_en,
  output iq_geom_pkg::iq_ptr_t [LANES-1:0] lane_addr,
  output iq_geom_pkg::iq_ptr_t [LANES-1:0] lane_addr_next
);

  import iq_geom_pkg::*;

  // a pointer plus a lane count stays well below 2*DEPTH
  localparam int SUM_W = $clog2(DEPTH + 2 * MAX_LANES);

  iq_ptr_t base;
  iq_ptr_t base_step;
  iq_ptr_t base_next;
  logic    en_contig;

  // ring add, one subtract is enough to wrap
  function automatic iq_ptr_t wrap_add(iq_ptr_t a, int unsigned b);
    logic [SUM_W-1:0] sum;
    sum = SUM_W'(a) + SUM_W'(b);
    if (sum >= SUM_W'(DEPTH)) begin
      sum = sum - SUM_W'(DEPTH);
    end
    return iq_ptr_t'(sum);
  endfunction

  // lanes are filled from lane 0 up, so the set bits give the step
  assign base_step = wrap_add(base, $countones(lane_en));

  always_comb begin
    if (flush) begin
      base_next = '0;
    end else if (advance) begin
      base_next = base_step;
    end else begin
      base_next = base;
    end
  end

  for (genvar i = 0; i < LANES; i++) begin : g_lane
    assign lane_addr[i]      = wrap_add(base, i);
    assign lane_addr_next[i] = wrap_add(base_next, i);
  end

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      base <= '0;
    end else if (advance) begin
      base <= base_step;
    end
  end

  // a gap in the lane mask would make the step skip a live lane
  assign en_contig = (lane_en & (lane_en + LANES'(1))) == '0;

  a_lane_en_contig: assert property (@(posedge clk) disable iff (rst)
    advance |-> en_contig);

endmodule

// File: logic/iq_occupancy.sv
`timescale 1ns/100ps

module iq_occupancy #(
  parameter int WR_LANES    = 4,
  parameter int RD_LANES    = 3,
  parameter int STALL_LEVEL = 12
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                flush,
  input  logic                init_busy,
  input  logic                wr_go,
  input  logic                rd_go,
  input  logic [WR_LANES-1:0] wr_lane_en,
  input  logic [RD_LANES-1:0] rd_lane_en,
  output logic                fetch_stall,
  output logic [RD_LANES-1:0] rd_avail
);

  import iq_geom_pkg::*;

  iq_count_t count;
  iq_count_t wr_num;
  iq_count_t rd_num;

  // ****************************************
  // up/down counter
  // ****************************************

  // lanes taken in and handed out on this edge
  assign wr_num = wr_go ? iq_count_t'($countones(wr_lane_en)) : '0;
  assign rd_num = rd_go ? iq_count_t'($countones(rd_lane_en)) : '0;

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      count <= '0;
    end else begin
      count <= count + wr_num - rd_num;
    end
  end

  // ****************************************
  // stall and availability
  // ****************************************

  // hold fetch once free space drops under one full write
  assign fetch_stall = init_busy || (count > iq_count_t'(STALL_LEVEL));

  // lane i can read only when more than i entries are held
  for (genvar i = 0; i < RD_LANES; i++) begin : g_avail
    assign rd_avail[i] = count > iq_count_t'(i);
  end

  // stall level must leave room for a full write
  a_count_bound: assert property (@(posedge clk) disable iff (rst)
    count <= iq_count_t'(DEPTH));

  // decode must only pop lanes that were offered
  a_pop_avail: assert property (@(posedge clk) disable iff (rst)
    rd_go |-> (rd_lane_en & ~rd_avail) == '0);

endmodule

// File: logic/iq_entry_array.sv
`timescale 1ns/100ps

module iq_entry_array #(
  parameter int WR_LANES = 4
) (
  input  logic                                                clk,
  input  logic                                                rst,
  input  logic                                                wr_go,
  input  logic                               [WR_LANES-1:0]  wr_lane_en,
  input  iq_geom_pkg::iq_ptr_t               [WR_LANES-1:0]  wr_addr,
  input  iq_payload_pkg::iq_instr_t          [WR_LANES-1:0]  wr_instr,
  input  iq_payload_pkg::iq_meta_t           [WR_LANES-1:0]  wr_meta,
  output iq_payload_pkg::iq_instr_t [iq_geom_pkg::DEPTH-1:0] entry_instr,
  output iq_payload_pkg::iq_meta_t  [iq_geom_pkg::DEPTH-1:0] entry_meta,
  output logic                                                init_busy
);

  import iq_geom_pkg::*;
  import iq_payload_pkg::*;

  logic      [DEPTH-1:0] wr_hit;
  iq_instr_t [DEPTH-1:0] wr_instr_sel;
  iq_meta_t  [DEPTH-1:0] wr_meta_sel;
  iq_ptr_t               sweep_ptr;
  logic                  addr_clash;

  // ****************************************
  // write lane decode
  // ****************************************

  // each entry picks the enabled lane aimed at it, if any
  always_comb begin
    for (int e = 0; e < DEPTH; e++) begin
      wr_hit[e]       = 1'b0;
      wr_instr_sel[e] = '0;
      wr_meta_sel[e]  = '0;
      for (int l = 0; l < WR_LANES; l++) begin
        if (wr_lane_en[l] && wr_addr[l] == iq_ptr_t'(e)) begin
          wr_hit[e]       = 1'b1;
          wr_instr_sel[e] = wr_instr[l];
          wr_meta_sel[e]  = wr_meta[l];
        end
      end
    end
  end

  // ****************************************
  // clearing sweep and storage
  // ****************************************

  always_ff @(posedge clk) begin
    if (rst) begin
      sweep_ptr <= '0;
      init_busy <= 1'b1;
    end else if (init_busy) begin
      sweep_ptr <= sweep_ptr + 1'b1;
      if (sweep_ptr == iq_ptr_t'(DEPTH - 1)) begin
        init_busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int e = 0; e < DEPTH; e++) begin
      if (init_busy) begin
        if (sweep_ptr == iq_ptr_t'(e)) begin
          entry_instr[e] <= '0;
          entry_meta[e]  <= '0;
        end
      end else if (wr_go && wr_hit[e]) begin
        entry_instr[e] <= wr_instr_sel[e];
        entry_meta[e]  <= wr_meta_sel[e];
      end
    end
  end

  // two lanes on one entry would drop a word
  always_comb begin
    addr_clash = 1'b0;
    for (int a = 0; a < WR_LANES; a++) begin
      for (int b = a + 1; b < WR_LANES; b++) begin
        if (wr_lane_en[a] && wr_lane_en[b] && wr_addr[a] == wr_addr[b]) begin
          addr_clash = 1'b1;
        end
      end
    end
  end

  a_no_addr_clash: assert property (@(posedge clk) disable iff (rst)
    wr_go |-> !addr_clash);

endmodule

// File: logic/iq_read_select.sv
`timescale 1ns/100ps

module iq_read_select #(
  parameter int RD_LANES = 3
) (
  input  logic                                                clk,
  input  logic                                                rst,
  input  logic                                                rd_go,
  input  iq_geom_pkg::iq_ptr_t               [RD_LANES-1:0]  rd_addr_next,
  input  logic                                                init_busy,
  input  iq_payload_pkg::iq_instr_t [iq_geom_pkg::DEPTH-1:0] entry_instr,
  input  iq_payload_pkg::iq_meta_t  [iq_geom_pkg::DEPTH-1:0] entry_meta,
  output iq_payload_pkg::iq_instr_t          [RD_LANES-1:0]  rd_instr,
  output iq_payload_pkg::iq_meta_t           [RD_LANES-1:0]  rd_meta
);

  import iq_geom_pkg::*;
  import iq_payload_pkg::*;

  localparam int ROW_W = $clog2(BANK_SIZE);

  logic [RD_LANES-1:0][NUM_BANKS-1:0] bank_oh;
  logic [RD_LANES-1:0][ROW_W-1:0]     row_sel;

  function automatic logic [NUM_BANKS-1:0] bank_of(iq_ptr_t a);
    logic [NUM_BANKS-1:0] oh;
    for (int b = 0; b < NUM_BANKS; b++) begin
      oh[b] = (int'(a) / BANK_SIZE) == b;
    end
    return oh;
  endfunction

  function automatic logic [ROW_W-1:0] row_of(iq_ptr_t a);
    return ROW_W'(int'(a) % BANK_SIZE);
  endfunction

  // select is loaded from the head the ring moves to
  always_ff @(posedge clk) begin
    for (int l = 0; l < RD_LANES; l++) begin
      if (rst) begin
        bank_oh[l] <= bank_of(iq_ptr_t'(l));
        row_sel[l] <= row_of(iq_ptr_t'(l));
      end else if (rd_go) begin
        bank_oh[l] <= bank_of(rd_addr_next[l]);
        row_sel[l] <= row_of(rd_addr_next[l]);
      end
    end
  end

  // one-hot bank pick, then the row inside that bank
  always_comb begin : p_mux
    iq_instr_t instr_pick;
    iq_meta_t  meta_pick;
    for (int l = 0; l < RD_LANES; l++) begin
      instr_pick = '0;
      meta_pick  = '0;
      for (int b = 0; b < NUM_BANKS; b++) begin
        if (bank_oh[l][b]) begin
          instr_pick = instr_pick | entry_instr[b * BANK_SIZE + int'(row_sel[l])];
          meta_pick  = meta_pick | entry_meta[b * BANK_SIZE + int'(row_sel[l])];
        end
      end
      // entries are half cleared during the sweep
      rd_instr[l] = init_busy ? '0 : instr_pick;
      rd_meta[l]  = init_busy ? '0 : meta_pick;
    end
  end

endmodule

// File: logic/iq_top.sv
`timescale 1ns/100ps

module iq_top #(
  parameter int WR_LANES = 4,
  parameter int RD_LANES = 3
) (
  input  logic                                       clk,
  input  logic                                       rst,
  input  logic                                       flush,
  // fetch side
  input  logic                                       wr_valid,
  input  logic                      [WR_LANES-1:0]  wr_lane_en,
  input  iq_payload_pkg::iq_instr_t [WR_LANES-1:0]  wr_instr,
  input  iq_payload_pkg::iq_meta_t  [WR_LANES-1:0]  wr_meta,
  output logic                                       fetch_stall,
  // decode side
  input  logic                                       rd_step,
  input  logic                      [RD_LANES-1:0]  rd_lane_en,
  output logic                      [RD_LANES-1:0]  rd_avail,
  output iq_payload_pkg::iq_instr_t [RD_LANES-1:0]  rd_instr,
  output iq_payload_pkg::iq_meta_t  [RD_LANES-1:0]  rd_meta
);

  import iq_geom_pkg::*;
  import iq_payload_pkg::*;

  // stall while less than one full write of space is left
  localparam int STALL_LEVEL = DEPTH - WR_LANES;

  logic                  wr_go;
  logic                  rd_go;
  logic                  head_load;
  logic                  init_busy;
  iq_ptr_t [WR_LANES-1:0] wr_addr;
  iq_ptr_t [RD_LANES-1:0] rd_addr_next;
  iq_instr_t [DEPTH-1:0] entry_instr;
  iq_meta_t  [DEPTH-1:0] entry_meta;

  // ****************************************
  // handshake strobes
  // ****************************************

  assign wr_go = wr_valid && !fetch_stall && !flush;
  assign rd_go = rd_step && !flush;

  // a flush moves the head too, so the read select reloads
  assign head_load = rd_go || flush;

  iq_lane_addr #(.LANES(WR_LANES)) u_wr_addr (
    .clk(clk), .rst(rst), .flush(flush), .advance(wr_go), .lane_en(wr_lane_en),
    .lane_addr(wr_addr), .lane_addr_next()
  );

  iq_lane_addr #(.LANES(RD_LANES)) u_rd_addr (
    .clk(clk), .rst(rst), .flush(flush), .advance(rd_go), .lane_en(rd_lane_en),
    .lane_addr(), .lane_addr_next(rd_addr_next)
  );

  iq_occupancy #(
    .WR_LANES(WR_LANES), .RD_LANES(RD_LANES), .STALL_LEVEL(STALL_LEVEL)
  ) u_occupancy (
    .clk(clk), .rst(rst), .flush(flush), .init_busy(init_busy),
    .wr_go(wr_go), .rd_go(rd_go), .wr_lane_en(wr_lane_en), .rd_lane_en(rd_lane_en),
    .fetch_stall(fetch_stall), .rd_avail(rd_avail)
  );

  iq_entry_array #(.WR_LANES(WR_LANES)) u_entry_array (
    .clk(clk), .rst(rst), .wr_go(wr_go), .wr_lane_en(wr_lane_en), .wr_addr(wr_addr),
    .wr_instr(wr_instr), .wr_meta(wr_meta), .entry_instr(entry_instr),
    .entry_meta(entry_meta), .init_busy(init_busy)
  );

  iq_read_select #(.RD_LANES(RD_LANES)) u_read_select (
    .clk(clk), .rst(rst), .rd_go(head_load), .rd_addr_next(rd_addr_next),
    .init_busy(init_busy), .entry_instr(entry_instr), .entry_meta(entry_meta),
    .rd_instr(rd_instr), .rd_meta(rd_meta)
  );

endmodule

// File: verif/iq_tb.sv
`timescale 1ns/100ps

module iq_tb;

  localparam int    WR_LANES    = 4;
  localparam int    RD_LANES    = 3;
  localparam int    DEPTH       = 16;
  localparam int    STALL_LEVEL = DEPTH - WR_LANES;
  localparam int    SWEEP_LIMIT = 4 * DEPTH;
  localparam string STIM_FILE   = "verif/iq_input.txt";

  logic                      clk;
  logic                      rst;
  logic                      flush;
  logic                      wr_valid;
  logic [WR_LANES-1:0]       wr_lane_en;
  logic [WR_LANES-1:0][31:0] wr_instr;
  logic [WR_LANES-1:0][7:0]  wr_meta;
  logic                      fetch_stall;
  logic                      rd_step;
  logic [RD_LANES-1:0]       rd_lane_en;
  logic [RD_LANES-1:0]       rd_avail;
  logic [RD_LANES-1:0][31:0] rd_instr;
  logic [RD_LANES-1:0][7:0]  rd_meta;

  // expected queue contents, head first
  logic [31:0] model_q[$];
  int          errors;
  int          checks;

  iq_top #(.WR_LANES(WR_LANES), .RD_LANES(RD_LANES)) u_iq_top (
    .clk(clk), .rst(rst), .flush(flush), .wr_valid(wr_valid), .wr_lane_en(wr_lane_en),
    .wr_instr(wr_instr), .wr_meta(wr_meta), .fetch_stall(fetch_stall), .rd_step(rd_step),
    .rd_lane_en(rd_lane_en), .rd_avail(rd_avail), .rd_instr(rd_instr), .rd_meta(rd_meta)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ****************************************
  // checks
  // ****************************************

  task automatic check_val(input string name, input logic [31:0] exp_val,
                           input logic [31:0] act_val);
    checks++;
    if (act_val !== exp_val) begin
      errors++;
      $display("ERROR %s: expected %h, actual %h", name, exp_val, act_val);
    end
  endtask

  task automatic check_zero(input string tag);
    for (int i = 0; i < RD_LANES; i++) begin
      check_val($sformatf("%s rd_instr[%0d]", tag, i), 32'd0, rd_instr[i]);
      check_val($sformatf("%s rd_meta[%0d]", tag, i), 32'd0, 32'(rd_meta[i]));
    end
  endtask

  // held entries show up on the lanes in push order
  task automatic check_lanes(input string tag);
    for (int i = 0; i < RD_LANES && i < model_q.size(); i++) begin
      check_val($sformatf("%s rd_instr[%0d]", tag, i), model_q[i], rd_instr[i]);
      check_val($sformatf("%s rd_meta[%0d]", tag, i), 32'(model_q[i][7:0]),
                32'(rd_meta[i]));
    end
    check_val($sformatf("%s fetch_stall", tag), 32'(model_q.size() > STALL_LEVEL),
              32'(fetch_stall));
  endtask

  function automatic bit is_step_op(input logic [63:0] op);
    return op == "push" || op == "pop" || op == "both" || op == "flush" || op == "idle";
  endfunction

  // ****************************************
  // stimulus and model
  // ****************************************

  task automatic apply_step(input logic [63:0] op, input logic [7:0] mask,
                            input logic [31:0] base);
    bit stalled;
    int n_rd;
    stalled    = model_q.size() > STALL_LEVEL;
    n_rd       = $countones(mask[4 +: RD_LANES]);
    flush      = op == "flush";
    wr_valid   = op == "push" || op == "both";
    rd_step    = op == "pop" || op == "both";
    wr_lane_en = mask[WR_LANES-1:0];
    rd_lane_en = mask[4 +: RD_LANES];
    for (int i = 0; i < WR_LANES; i++) begin
      wr_instr[i] = base + 32'(i);
      wr_meta[i]  = wr_instr[i][7:0];
    end
    if (flush) begin
      model_q.delete();
    end
    if (rd_step) begin
      if (n_rd > model_q.size()) begin
        errors++;
        $display("stimulus pops %0d lanes while only %0d entries are held", n_rd,
                 model_q.size());
      end
      while (n_rd > 0 && model_q.size() > 0) begin
        void'(model_q.pop_front());
        n_rd--;
      end
    end
    // a write offered during a stall is lost
    if (wr_valid && !stalled) begin
      for (int i = 0; i < $countones(wr_lane_en); i++) begin
        model_q.push_back(base + 32'(i));
      end
    end
  endtask

  task automatic wait_sweep(output bit done);
    int cycles;
    cycles = 0;
    // full-width writes offered during the sweep must all be refused
    wr_valid   = 1'b1;
    wr_lane_en = '1;
    for (int i = 0; i < WR_LANES; i++) begin
      wr_instr[i] = 32'h5a5a_5aa0 + 32'(i);
      wr_meta[i]  = wr_instr[i][7:0];
    end
    while (fetch_stall && cycles < SWEEP_LIMIT) begin
      check_val("sweep rd_avail", 32'd0, 32'(rd_avail));
      check_zero("sweep");
      @(posedge clk);
      #2;
      cycles++;
    end
    wr_valid   = 1'b0;
    wr_lane_en = '0;
    done = !fetch_stall;
    if (done) begin
      check_val("sweep cycles", DEPTH, cycles);
      check_val("after sweep rd_avail", 32'd0, 32'(rd_avail));
      check_zero("after sweep");
    end else begin
      errors++;
      $display("timeout: fetch_stall still high %0d cycles after reset", cycles);
    end
  endtask

  task automatic run_stimulus();
    logic [8*128-1:0] line;
    logic [63:0]      op;
    logic [7:0]       mask;
    logic [7:0]       exp_avail;
    logic [31:0]      base;
    int               fd;
    int               n;
    int               line_no;
    string            tag;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      errors++;
      $display("cannot open stimulus file %s", STIM_FILE);
    end else begin
      line_no = 0;
      line    = '0;
      while ($fgets(line, fd) != 0) begin
        line_no++;
        op = '0;
        n  = $sscanf(line, "%s %h %h %h", op, mask, base, exp_avail);
        if (n >= 1 && op != "#") begin
          if (n != 4 || !is_step_op(op)) begin
            errors++;
            $display("line %0d of %s is not a valid step", line_no, STIM_FILE);
          end else begin
            tag = $sformatf("line %0d", line_no);
            apply_step(op, mask, base);
            @(posedge clk);
            #2;
            check_val($sformatf("%s rd_avail", tag), 32'(exp_avail[RD_LANES-1:0]),
                      32'(rd_avail));
            check_lanes(tag);
          end
        end
        line = '0;
      end
      $fclose(fd);
    end
  endtask

  initial begin
    bit swept;
    errors = 0;
    checks = 0;
    rst    = 1'b1;
    apply_step("idle", 8'h00, 32'h0);
    repeat (2) @(posedge clk);
    #2;
    rst = 1'b0;
    wait_sweep(swept);
    if (swept) begin
      run_stimulus();
    end
    apply_step("idle", 8'h00, 32'h0);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: verif/iq_input.txt
# op (push pop both flush idle), mask (read lanes high hex digit, write lanes low digit)
# base (payload of write lane 0, lane i carries base + i), avail (rd_avail after the edge)
# ordering across lanes
push 0f 00000100 7
push 03 00000200 7
pop 30 00000000 7
pop 70 00000000 1
pop 10 00000000 0
push 01 00000300 1
push 01 00000301 3
pop 30 00000000 0
push 0f 00000400 7
push 0f 00000410 7
pop 70 00000000 7
push 07 00000420 7
pop 70 00000000 7
pop 70 00000000 3
pop 30 00000000 0
# stall and simultaneous push and pop
push 0f 00000500 7
push 0f 00000510 7
push 0f 00000520 7
push 01 00000530 7
push 0f 00000540 7
push 03 00000550 7
both 1f 00000560 7
pop 70 00000000 7
both 3f 00000600 7
both 71 00000610 7
both 7f 00000620 7
both 11 00000630 7
# flush
flush 00 00000000 0
push 07 00000700 7
pop 30 00000000 1
both 13 00000710 3
pop 30 00000000 0
push 0f 00000800 7
flush 00 00000000 0
idle 00 00000000 0
push 01 00000900 1
pop 10 00000000 0

// File: build.f
logic/iq_geom_pkg.sv
logic/iq_payload_pkg.sv
logic/iq_lane_addr.sv
logic/iq_occupancy.sv
logic/iq_entry_array.sv
logic/iq_read_select.sv
logic/iq_top.sv
verif/iq_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build the queue testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module iq_tb -f build.f \
  -Mdir obj_dir -o iq_sim > build.log 2>&1 \
  && ./obj_dir/iq_sim > sim.log 2>&1 \
  || { echo "build or run failed, see build.log and sim.log"; exit 1; }

grep -q "SIMULATION FAILED" sim.log && { echo "testbench reported failure"; exit 1; }
echo "testbench run clean"
